// File: compile.f
rtl/cpuPkg.sv
rtl/arithmeticUnit.sv
rtl/instructionDecoder.sv
rtl/programSequencer.sv
rtl/registerBank.sv
rtl/dataMemory.sv
rtl/processorCore.sv
testbench/processorCoreTb.sv

// File: runSim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module processorCoreTb \
    -f compile.f -o simProcessorCore

./obj_dir/simProcessorCore > sim.log 2>&1 || true
cat sim.log

if grep -q "^>>> PASS$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

// File: testbench/processorCoreTb.sv
`default_nettype none

module processorCoreTb;

    localparam int clockPeriod = 4;
    localparam int resetCycles = 5;
    localparam int programLength = 128;
    localparam int watchdogCycles = programLength * 4 + 100;
    localparam logic [31:0] haltAddress = 32'd100;

    logic clock;
    logic reset;
    logic run;
    cpuPkg::instructionWord instruction;
    logic [31:0] instructionAddress;
    logic dataWriteValid;
    logic [7:0] dataWriteAddress;
    logic [31:0] dataWriteData;
    logic privileged;
    logic [31:0] stackPointer;

    cpuPkg::instructionWord programImage [0:programLength-1];
    logic [15:0] lfsrState = 16'd4;
    int errorCount = 0;
    int storeCount = 0;
    int stallCount = 0;

    // reference model state.
    logic [31:0] modelReg [0:15];
    logic [31:0] modelMem [0:cpuPkg::memoryDepth-1];
    logic [31:0] modelPc;
    logic [31:0] modelUserSp;
    logic [31:0] modelPrivSp;
    logic modelPriv;

    cpuPkg::instructionWord fetched;
    logic [31:0] liveSp;
    logic [31:0] effectiveAddress;
    logic [31:0] pushAddress;
    logic expectValid;
    logic [7:0] expectAddress;
    logic [31:0] expectData;

    processorCore i_dut (
        .clock(clock), .reset(reset), .run(run), .instruction(instruction),
        .instructionAddress(instructionAddress), .dataWriteValid(dataWriteValid),
        .dataWriteAddress(dataWriteAddress), .dataWriteData(dataWriteData),
        .privileged(privileged), .stackPointer(stackPointer)
    );

    always #(clockPeriod / 2) clock = ~clock;

    // fetch is combinational, so the program answers the current address at once.
    assign instruction = programImage[instructionAddress[6:0]];

    function automatic cpuPkg::instructionWord regOp(input logic [3:0] opcode,
            input logic [3:0] dest, input logic [3:0] sourceA, input logic [3:0] sourceB);
        cpuPkg::instructionWord word;
        word.registerView.opcode = opcode;
        word.registerView.dest = dest;
        word.registerView.sourceA = sourceA;
        word.registerView.sourceB = sourceB;
        word.registerView.spare = 16'd0;
        return word;
    endfunction

    function automatic cpuPkg::instructionWord immOp(input logic [3:0] opcode,
            input logic [3:0] dest, input logic [3:0] sourceA, input logic [19:0] immediate);
        cpuPkg::instructionWord word;
        word.immediateView.opcode = opcode;
        word.immediateView.dest = dest;
        word.immediateView.sourceA = sourceA;
        word.immediateView.immediate = immediate;
        return word;
    endfunction

    // 16-bit Fibonacci LFSR with taps 16, 15, 13 and 4.
    function automatic logic [15:0] lfsrNext(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[14] ^ state[12] ^ state[3]};
    endfunction

    function automatic logic randomBit();
        lfsrState = lfsrNext(lfsrState);
        return lfsrState[0];
    endfunction

    // run drops in about one cycle of four.
    function automatic logic nextRunLevel();
        logic first;
        logic second;
        first = randomBit();
        second = randomBit();
        return !(first && second);
    endfunction

    function automatic logic [31:0] readReg(input logic [3:0] index, input logic [31:0] sp);
        if (index == cpuPkg::userStackIndex) begin
            return sp;
        end else if (index == cpuPkg::programCounterIndex) begin
            return modelPc;
        end
        return modelReg[index];
    endfunction

    task automatic loadProgram();
        // unused slots are NOPs that carry their own address in the spare field.
        for (int i = 0; i < programLength; i++) begin
            programImage[i] = regOp(cpuPkg::opNop, 4'd0, 4'd0, 4'd0);
            programImage[i].registerView.spare = 16'(i);
        end
        programImage[0] = immOp(cpuPkg::opAddImm, 4'd1, 4'd0, 20'h00123);
        programImage[1] = immOp(cpuPkg::opAddImm, 4'd2, 4'd0, 20'h00010);
        programImage[2] = immOp(cpuPkg::opStore, 4'd0, 4'd2, 20'd3);
        programImage[3] = regOp(cpuPkg::opAdd, 4'd3, 4'd1, 4'd2);
        programImage[4] = regOp(cpuPkg::opSub, 4'd4, 4'd1, 4'd2);
        programImage[5] = regOp(cpuPkg::opAnd, 4'd5, 4'd1, 4'd2);
        programImage[6] = regOp(cpuPkg::opOr, 4'd6, 4'd1, 4'd2);
        programImage[7] = regOp(cpuPkg::opXor, 4'd7, 4'd1, 4'd2);
        for (int i = 0; i < 5; i++) begin
            programImage[8 + i] = immOp(cpuPkg::opStore, 4'(3 + i), 4'd0, 20'(4 + i));
        end
        programImage[13] = immOp(cpuPkg::opLoad, 4'd8, 4'd0, 20'd4);
        programImage[14] = immOp(cpuPkg::opStore, 4'd8, 4'd0, 20'd9);
        programImage[15] = regOp(cpuPkg::opPush, 4'd1, 4'd0, 4'd0);
        programImage[16] = regOp(cpuPkg::opPush, 4'd4, 4'd0, 4'd0);
        programImage[17] = regOp(cpuPkg::opPop, 4'd9, 4'd0, 4'd0);
        programImage[18] = regOp(cpuPkg::opPop, 4'd10, 4'd0, 4'd0);
        programImage[19] = immOp(cpuPkg::opStore, 4'd9, 4'd0, 20'd10);
        programImage[20] = immOp(cpuPkg::opStore, 4'd10, 4'd0, 20'd11);
        programImage[21] = immOp(cpuPkg::opAddImm, 4'd14, 4'd0, 20'd7);
        programImage[22] = regOp(cpuPkg::opAdd, 4'd15, 4'd1, 4'd2);
        programImage[23] = immOp(cpuPkg::opStore, 4'd14, 4'd0, 20'd12);
        programImage[24] = regOp(cpuPkg::opPush, 4'd6, 4'd0, 4'd0);
        programImage[25] = regOp(cpuPkg::opTrap, 4'd0, 4'd0, 4'd0);
        programImage[26] = immOp(cpuPkg::opStore, 4'd13, 4'd0, 20'd14);
        programImage[27] = regOp(cpuPkg::opPop, 4'd11, 4'd0, 4'd0);
        programImage[28] = immOp(cpuPkg::opStore, 4'd11, 4'd0, 20'd16);
        programImage[29] = immOp(cpuPkg::opJump, 4'd0, 4'd0, 20'(haltAddress));

        // trap handler, running on the privileged stack.
        programImage[64] = immOp(cpuPkg::opStore, 4'd13, 4'd0, 20'd13);
        programImage[65] = regOp(cpuPkg::opPush, 4'd2, 4'd0, 4'd0);
        programImage[66] = immOp(cpuPkg::opAddImm, 4'd0, 4'd0, 20'h00055);
        programImage[67] = immOp(cpuPkg::opStore, 4'd0, 4'd0, 20'd1);
        programImage[68] = regOp(cpuPkg::opResetContext, 4'd0, 4'd0, 4'd0);
        programImage[69] = immOp(cpuPkg::opStore, 4'd0, 4'd0, 20'd15);
        programImage[70] = regOp(cpuPkg::opPush, 4'd3, 4'd0, 4'd0);
        programImage[71] = regOp(cpuPkg::opPop, 4'd12, 4'd0, 4'd0);
        programImage[72] = regOp(cpuPkg::opReturn, 4'd0, 4'd0, 4'd0);

        programImage[100] = immOp(cpuPkg::opJump, 4'd0, 4'd0, 20'(haltAddress));
    endtask

    // **************************************************
    // reference model
    // **************************************************

    always_comb begin
        fetched = programImage[modelPc[6:0]];
        liveSp = modelPriv ? modelPrivSp : modelUserSp;
        effectiveAddress = readReg(fetched.immediateView.sourceA, liveSp) +
                           {12'd0, fetched.immediateView.immediate};
        pushAddress = liveSp - 32'd1;
        expectValid = run && (fetched.registerView.opcode == cpuPkg::opStore ||
                              fetched.registerView.opcode == cpuPkg::opPush);
        if (fetched.registerView.opcode == cpuPkg::opPush) begin
            expectAddress = pushAddress[7:0];
        end else begin
            expectAddress = effectiveAddress[7:0];
        end
        expectData = readReg(fetched.registerView.dest, liveSp);
    end

    always @(posedge clock or posedge reset) begin
        logic [31:0] valueA;
        logic [31:0] valueB;
        logic [31:0] result;
        logic [31:0] nextPc;
        logic [31:0] nextSp;
        logic [3:0] dest;
        logic writeBack;
        if (reset) begin
            for (int i = 0; i < 16; i++) begin
                modelReg[i] <= 32'd0;
            end
            modelReg[0] <= cpuPkg::dataAreaStart;
            modelPc <= 32'd0;
            modelUserSp <= cpuPkg::stackTop;
            modelPrivSp <= cpuPkg::stackTop;
            modelPriv <= 1'b0;
        end else if (!run) begin
            stallCount <= stallCount + 1;
        end else begin
            valueA = readReg(fetched.registerView.sourceA, liveSp);
            valueB = readReg(fetched.registerView.sourceB, liveSp);
            dest = fetched.registerView.dest;
            nextPc = modelPc + 32'd1;
            nextSp = liveSp;
            result = 32'd0;
            writeBack = 1'b0;
            case (fetched.registerView.opcode)
                cpuPkg::opAdd: begin
                    result = valueA + valueB;
                    writeBack = 1'b1;
                end
                cpuPkg::opSub: begin
                    result = valueA - valueB;
                    writeBack = 1'b1;
                end
                cpuPkg::opAnd: begin
                    result = valueA & valueB;
                    writeBack = 1'b1;
                end
                cpuPkg::opOr: begin
                    result = valueA | valueB;
                    writeBack = 1'b1;
                end
                cpuPkg::opXor: begin
                    result = valueA ^ valueB;
                    writeBack = 1'b1;
                end
                cpuPkg::opAddImm: begin
                    result = effectiveAddress;
                    writeBack = 1'b1;
                end
                cpuPkg::opLoad: begin
                    result = modelMem[effectiveAddress[7:0]];
                    writeBack = 1'b1;
                end
                cpuPkg::opStore: begin
                    modelMem[expectAddress] <= expectData;
                    storeCount <= storeCount + 1;
                end
                cpuPkg::opPush: begin
                    modelMem[expectAddress] <= expectData;
                    storeCount <= storeCount + 1;
                    nextSp = pushAddress;
                end
                cpuPkg::opPop: begin
                    result = modelMem[liveSp[7:0]];
                    writeBack = 1'b1;
                    nextSp = liveSp + 32'd1;
                end
                cpuPkg::opJump: begin
                    nextPc = {12'd0, fetched.immediateView.immediate};
                end
                cpuPkg::opTrap: begin
                    modelReg[cpuPkg::linkIndex] <= modelPc;
                    modelPriv <= 1'b1;
                    nextPc = cpuPkg::trapVector;
                end
                cpuPkg::opReturn: begin
                    modelPriv <= 1'b0;
                    nextPc = modelReg[cpuPkg::linkIndex] + 32'd1;
                end
                cpuPkg::opResetContext: begin
                    modelReg[0] <= cpuPkg::dataAreaStart;
                    nextSp = cpuPkg::stackTop;
                end
                default: begin
                end
            endcase
            modelPc <= nextPc;
            if (modelPriv) begin
                modelPrivSp <= nextSp;
            end else begin
                modelUserSp <= nextSp;
            end
            // results never land in the stack pointer or program counter slots.
            if (writeBack && dest != cpuPkg::userStackIndex &&
                    dest != cpuPkg::programCounterIndex) begin
                modelReg[dest] <= result;
            end
        end
    end

    // **************************************************
    // checks
    // **************************************************

    afterReset: assert property (@(posedge clock) $fell(reset) |->
        (instructionAddress == 32'd0 && !privileged &&
         stackPointer == cpuPkg::stackTop && !dataWriteValid))
        else begin
            errorCount = errorCount + 1;
            $display("MISMATCH at %0t: state after reset is wrong", $time);
        end

    pcMatch: assert property (@(posedge clock) disable iff (reset)
        instructionAddress == modelPc)
        else begin
            errorCount = errorCount + 1;
            $display("MISMATCH at %0t: instructionAddress %0d, expected %0d",
                     $time, instructionAddress, modelPc);
        end

    modeMatch: assert property (@(posedge clock) disable iff (reset) privileged == modelPriv)
        else begin
            errorCount = errorCount + 1;
            $display("MISMATCH at %0t: privileged %0b, expected %0b",
                     $time, privileged, modelPriv);
        end

    stackMatch: assert property (@(posedge clock) disable iff (reset) stackPointer == liveSp)
        else begin
            errorCount = errorCount + 1;
            $display("MISMATCH at %0t: stackPointer %h, expected %h", $time, stackPointer, liveSp);
        end

    writeValidMatch: assert property (@(posedge clock) disable iff (reset)
        dataWriteValid == expectValid)
        else begin
            errorCount = errorCount + 1;
            $display("MISMATCH at %0t: dataWriteValid %0b, expected %0b",
                     $time, dataWriteValid, expectValid);
        end

    writeMatch: assert property (@(posedge clock) disable iff (reset)
        expectValid |-> (dataWriteAddress == expectAddress && dataWriteData == expectData))
        else begin
            errorCount = errorCount + 1;
            $display("MISMATCH at %0t: store to %h of %h, expected %h of %h", $time,
                     dataWriteAddress, dataWriteData, expectAddress, expectData);
        end

    stallHolds: assert property (@(posedge clock) disable iff (reset)
        !run |=> ($stable(instructionAddress) && $stable(stackPointer)))
        else begin
            errorCount = errorCount + 1;
            $display("MISMATCH at %0t: state moved while run was low", $time);
        end

    stallSilent: assert property (@(posedge clock) disable iff (reset) !run |-> !dataWriteValid)
        else begin
            errorCount = errorCount + 1;
            $display("MISMATCH at %0t: store signalled while run was low", $time);
        end

    initial begin
        #(watchdogCycles * clockPeriod);
        $display("timeout: the program did not reach its halt loop in %0d cycles", watchdogCycles);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        run = 1'b0;
        loadProgram();
        repeat (resetCycles) @(posedge clock);
        reset <= 1'b0;
        while (instructionAddress != haltAddress) begin
            @(posedge clock);
            run <= nextRunLevel();
        end
        repeat (8) begin
            @(posedge clock);
            run <= nextRunLevel();
        end
        @(negedge clock);
        if (storeCount == 0) begin
            errorCount = errorCount + 1;
            $display("no store was committed during the run");
        end
        if (stallCount == 0) begin
            errorCount = errorCount + 1;
            $display("run was never low, so the stall checks were not reached");
        end
        $display("errors: %0d, stores: %0d, stalled cycles: %0d",
                 errorCount, storeCount, stallCount);
        if (errorCount == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/processorCore.sv
`default_nettype none

module processorCore (
    input wire logic clock,
    input wire logic reset,
    input wire logic run,
    input wire cpuPkg::instructionWord instruction,
    output logic [cpuPkg::wordWidth-1:0] instructionAddress,
    output logic dataWriteValid,
    output logic [7:0] dataWriteAddress,
    output logic [cpuPkg::wordWidth-1:0] dataWriteData,
    output logic privileged,
    output logic [cpuPkg::wordWidth-1:0] stackPointer
);

    logic [3:0] sourceA;
    logic [3:0] sourceB;
    logic [3:0] dest;
    logic [19:0] immediate;
    logic [2:0] aluOperation;
    logic [2:0] bankAction;
    logic useImmediate;
    logic memoryWrite;
    logic stackPush;
    logic stackPop;
    logic jump;
    logic trap;
    logic returnFromTrap;
    logic [cpuPkg::wordWidth-1:0] readDataA;
    logic [cpuPkg::wordWidth-1:0] readDataB;
    logic [cpuPkg::wordWidth-1:0] aluResult;
    logic [cpuPkg::wordWidth-1:0] memoryData;
    logic [cpuPkg::wordWidth-1:0] newPc;
    logic [cpuPkg::wordWidth-1:0] newStackPointer;

    // the observed write address is also the read address for load and pop.
    assign dataWriteAddress = stackPush ? newStackPointer[7:0] : aluResult[7:0];
    assign dataWriteValid = run & (memoryWrite | stackPush);

    instructionDecoder i_decoder (
        .instruction(instruction), .sourceA(sourceA), .sourceB(sourceB), .dest(dest),
        .immediate(immediate), .aluOperation(aluOperation), .useImmediate(useImmediate),
        .memoryWrite(memoryWrite), .stackPush(stackPush), .stackPop(stackPop),
        .jump(jump), .trap(trap), .returnFromTrap(returnFromTrap), .bankAction(bankAction)
    );

    registerBank i_bank (
        .clock(clock), .reset(reset), .enable(run), .sourceA(sourceA), .sourceB(sourceB),
        .dest(dest), .bankAction(bankAction), .privileged(privileged),
        .aluResult(aluResult), .memoryData(memoryData), .newPc(newPc),
        .newStackPointer(newStackPointer), .readDataA(readDataA), .readDataB(readDataB),
        .storeData(dataWriteData), .currentPc(instructionAddress), .currentSp(stackPointer)
    );

    arithmeticUnit i_alu (
        .operation(aluOperation), .operandA(readDataA), .registerB(readDataB),
        .immediate(immediate), .useImmediate(useImmediate), .result(aluResult)
    );

    programSequencer i_sequencer (
        .clock(clock), .reset(reset), .enable(run), .currentPc(instructionAddress),
        .currentSp(stackPointer), .linkValue(readDataB), .immediate(immediate),
        .jump(jump), .trap(trap), .returnFromTrap(returnFromTrap), .stackPush(stackPush),
        .stackPop(stackPop), .newPc(newPc), .newStackPointer(newStackPointer),
        .privileged(privileged)
    );

    dataMemory i_memory (
        .clock(clock), .writeEnable(dataWriteValid), .address(dataWriteAddress),
        .writeData(dataWriteData), .readData(memoryData)
    );

endmodule

`default_nettype wire

// File: rtl/dataMemory.sv
`default_nettype none

module dataMemory (
    input wire logic clock,
    input wire logic writeEnable,
    input wire logic [7:0] address,
    input wire logic [cpuPkg::wordWidth-1:0] writeData,
    output logic [cpuPkg::wordWidth-1:0] readData
);

    logic [cpuPkg::wordWidth-1:0] storage [0:cpuPkg::memoryDepth-1];

    // reads are combinational so a load completes in its own cycle.
    assign readData = storage[address];

    always_ff @(posedge clock) begin
        if (writeEnable) begin
            storage[address] <= writeData;
        end
    end

endmodule

`default_nettype wire

// File: rtl/registerBank.sv
`default_nettype none

module registerBank (
    input wire logic clock,
    input wire logic reset,
    input wire logic enable,
    input wire logic [3:0] sourceA,
    input wire logic [3:0] sourceB,
    input wire logic [3:0] dest,
    input wire logic [2:0] bankAction,
    input wire logic privileged,
    input wire logic [cpuPkg::wordWidth-1:0] aluResult,
    input wire logic [cpuPkg::wordWidth-1:0] memoryData,
    input wire logic [cpuPkg::wordWidth-1:0] newPc,
    input wire logic [cpuPkg::wordWidth-1:0] newStackPointer,
    output logic [cpuPkg::wordWidth-1:0] readDataA,
    output logic [cpuPkg::wordWidth-1:0] readDataB,
    output logic [cpuPkg::wordWidth-1:0] storeData,
    output logic [cpuPkg::wordWidth-1:0] currentPc,
    output logic [cpuPkg::wordWidth-1:0] currentSp
);

    logic [cpuPkg::wordWidth-1:0] bank [0:cpuPkg::privilegedStackIndex];
    logic [4:0] spIndex;
    logic destIsSpecial;

    // slot 14 is only an alias, the live stack depends on the mode.
    assign spIndex = privileged ? cpuPkg::privilegedStackIndex : {1'b0, cpuPkg::userStackIndex};
    assign currentSp = bank[spIndex];
    assign currentPc = bank[cpuPkg::programCounterIndex];

    assign readDataA = (sourceA == cpuPkg::userStackIndex) ? currentSp : bank[sourceA];
    assign readDataB = (sourceB == cpuPkg::userStackIndex) ? currentSp : bank[sourceB];
    assign storeData = (dest == cpuPkg::userStackIndex) ? currentSp : bank[dest];

    assign destIsSpecial = (dest == cpuPkg::userStackIndex) ||
                           (dest == cpuPkg::programCounterIndex);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i <= int'(cpuPkg::privilegedStackIndex); i++) begin
                bank[i] <= '0;
            end
            bank[0] <= cpuPkg::dataAreaStart;
            bank[cpuPkg::userStackIndex] <= cpuPkg::stackTop;
            bank[cpuPkg::privilegedStackIndex] <= cpuPkg::stackTop;
        end else if (enable) begin
            bank[cpuPkg::programCounterIndex] <= newPc;
            if (bankAction == cpuPkg::actionResetContext) begin
                bank[spIndex] <= cpuPkg::stackTop;
            end else begin
                bank[spIndex] <= newStackPointer;
            end

            case (bankAction)
                cpuPkg::actionWriteAlu: begin
                    if (!destIsSpecial) begin
                        bank[dest] <= aluResult;
                    end
                end
                cpuPkg::actionResetContext: begin
                    bank[0] <= cpuPkg::dataAreaStart;
                end
                cpuPkg::actionWriteMemory: begin
                    if (!destIsSpecial) begin
                        bank[dest] <= memoryData;
                    end
                end
                cpuPkg::actionEnterPrivileged: begin
                    // the link register keeps the address of the trap itself.
                    bank[cpuPkg::linkIndex] <= bank[cpuPkg::programCounterIndex];
                end
                default: begin
                end
            endcase
        end
    end

    pcKnown: assert property (@(posedge clock) disable iff (reset) !$isunknown(currentPc))
        else $error("program counter is unknown");

    // a result aimed at slot 14 or 15 must leave only the sequencer's updates there.
    aluSpareSpecial: assert property (@(posedge clock) disable iff (reset)
        (enable && bankAction == cpuPkg::actionWriteAlu) |=>
            (bank[cpuPkg::programCounterIndex] == $past(newPc)) &&
            (bank[cpuPkg::userStackIndex] ==
                $past(privileged ? bank[cpuPkg::userStackIndex] : newStackPointer)))
        else $error("arithmetic write disturbed the program counter or user stack");

endmodule

`default_nettype wire

// File: rtl/programSequencer.sv
`default_nettype none

module programSequencer (
    input wire logic clock,
    input wire logic reset,
    input wire logic enable,
    input wire logic [cpuPkg::wordWidth-1:0] currentPc,
    input wire logic [cpuPkg::wordWidth-1:0] currentSp,
    input wire logic [cpuPkg::wordWidth-1:0] linkValue,
    input wire logic [19:0] immediate,
    input wire logic jump,
    input wire logic trap,
    input wire logic returnFromTrap,
    input wire logic stackPush,
    input wire logic stackPop,
    output logic [cpuPkg::wordWidth-1:0] newPc,
    output logic [cpuPkg::wordWidth-1:0] newStackPointer,
    output logic privileged
);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            privileged <= 1'b0;
        end else if (enable) begin
            if (trap) begin
                privileged <= 1'b1;
            end else if (returnFromTrap) begin
                privileged <= 1'b0;
            end
        end
    end

    always_comb begin
        if (trap) begin
            newPc = cpuPkg::trapVector;
        end else if (returnFromTrap) begin
            // resume after the trap instruction.
            newPc = linkValue + 1'b1;
        end else if (jump) begin
            newPc = {{(cpuPkg::wordWidth - 20){1'b0}}, immediate};
        end else begin
            newPc = currentPc + 1'b1;
        end
    end

    always_comb begin
        if (stackPush) begin
            newStackPointer = currentSp - 1'b1;
        end else if (stackPop) begin
            newStackPointer = currentSp + 1'b1;
        end else begin
            newStackPointer = currentSp;
        end
    end

    enterOnTrapOnly: assert property (@(posedge clock) disable iff (reset)
        $rose(privileged) |-> $past(trap && enable))
        else $error("privileged mode entered without a trap");

endmodule

`default_nettype wire

// File: rtl/instructionDecoder.sv
`default_nettype none

module instructionDecoder (
    input wire cpuPkg::instructionWord instruction,
    output logic [3:0] sourceA,
    output logic [3:0] sourceB,
    output logic [3:0] dest,
    output logic [19:0] immediate,
    output logic [2:0] aluOperation,
    output logic useImmediate,
    output logic memoryWrite,
    output logic stackPush,
    output logic stackPop,
    output logic jump,
    output logic trap,
    output logic returnFromTrap,
    output logic [2:0] bankAction
);

    always_comb begin
        sourceA = instruction.registerView.sourceA;
        sourceB = instruction.registerView.sourceB;
        dest = instruction.registerView.dest;
        immediate = instruction.immediateView.immediate;
        aluOperation = cpuPkg::aluAdd;
        useImmediate = 1'b0;
        memoryWrite = 1'b0;
        stackPush = 1'b0;
        stackPop = 1'b0;
        jump = 1'b0;
        trap = 1'b0;
        returnFromTrap = 1'b0;
        bankAction = cpuPkg::actionNone;

        case (instruction.registerView.opcode)
            cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAnd, cpuPkg::opOr, cpuPkg::opXor: begin
                // the low opcode bits line up with the arithmetic codes.
                aluOperation = instruction.registerView.opcode[2:0];
                bankAction = cpuPkg::actionWriteAlu;
            end
            cpuPkg::opAddImm, cpuPkg::opLoad, cpuPkg::opStore: begin
                useImmediate = 1'b1;
                if (instruction.immediateView.opcode == cpuPkg::opAddImm) begin
                    bankAction = cpuPkg::actionWriteAlu;
                end else if (instruction.immediateView.opcode == cpuPkg::opLoad) begin
                    bankAction = cpuPkg::actionWriteMemory;
                end else begin
                    memoryWrite = 1'b1;
                end
            end
            cpuPkg::opPush: begin
                stackPush = 1'b1;
            end
            cpuPkg::opPop: begin
                // the pop address is the stack pointer, read back through source B.
                sourceB = cpuPkg::userStackIndex;
                aluOperation = cpuPkg::aluPassB;
                stackPop = 1'b1;
                bankAction = cpuPkg::actionWriteMemory;
            end
            cpuPkg::opJump: begin
                jump = 1'b1;
            end
            cpuPkg::opTrap: begin
                trap = 1'b1;
                bankAction = cpuPkg::actionEnterPrivileged;
            end
            cpuPkg::opReturn: begin
                sourceB = cpuPkg::linkIndex;
                returnFromTrap = 1'b1;
            end
            cpuPkg::opResetContext: begin
                bankAction = cpuPkg::actionResetContext;
            end
            cpuPkg::opNop: begin
                bankAction = cpuPkg::actionNone;
            end
            default: begin
                bankAction = cpuPkg::actionNone;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/arithmeticUnit.sv
`default_nettype none

module arithmeticUnit (
    input wire logic [2:0] operation,
    input wire logic [cpuPkg::wordWidth-1:0] operandA,
    input wire logic [cpuPkg::wordWidth-1:0] registerB,
    input wire logic [19:0] immediate,
    input wire logic useImmediate,
    output logic [cpuPkg::wordWidth-1:0] result
);

    logic [cpuPkg::wordWidth-1:0] operandB;
    logic [cpuPkg::wordWidth-1:0] extendedImmediate;

    // immediates are zero-extended, never sign-extended.
    assign extendedImmediate = {{(cpuPkg::wordWidth - 20){1'b0}}, immediate};
    assign operandB = useImmediate ? extendedImmediate : registerB;

    // **************************************************
    // operation select
    // **************************************************

    always_comb begin
        case (operation)
            cpuPkg::aluAdd: begin
                result = operandA + operandB;
            end
            cpuPkg::aluSub: begin
                result = operandA - operandB;
            end
            cpuPkg::aluAnd: begin
                result = operandA & operandB;
            end
            cpuPkg::aluOr: begin
                result = operandA | operandB;
            end
            cpuPkg::aluXor: begin
                result = operandA ^ operandB;
            end
            cpuPkg::aluPassB: begin
                result = operandB;
            end
            default: begin
                result = operandB;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/cpuPkg.sv
`default_nettype none

package cpuPkg;

    // **************************************************
    // architectural constants
    // **************************************************

    localparam int wordWidth = 32;
    localparam int memoryDepth = 256;

    localparam logic [wordWidth-1:0] dataAreaStart = 32'd8192;
    localparam logic [wordWidth-1:0] stackTop = '1;
    localparam logic [wordWidth-1:0] trapVector = 32'd64;

    // physical slots in the register bank.
    localparam logic [3:0] linkIndex = 4'd13;
    localparam logic [3:0] userStackIndex = 4'd14;
    localparam logic [3:0] programCounterIndex = 4'd15;
    localparam logic [4:0] privilegedStackIndex = 5'd16;

    // **************************************************
    // opcodes, arithmetic operations and bank actions
    // **************************************************

    localparam logic [3:0] opAdd = 4'd0;
    localparam logic [3:0] opSub = 4'd1;
    localparam logic [3:0] opAnd = 4'd2;
    localparam logic [3:0] opOr = 4'd3;
    localparam logic [3:0] opXor = 4'd4;
    localparam logic [3:0] opAddImm = 4'd5;
    localparam logic [3:0] opLoad = 4'd6;
    localparam logic [3:0] opStore = 4'd7;
    localparam logic [3:0] opPush = 4'd8;
    localparam logic [3:0] opPop = 4'd9;
    localparam logic [3:0] opJump = 4'd10;
    localparam logic [3:0] opTrap = 4'd11;
    localparam logic [3:0] opReturn = 4'd12;
    localparam logic [3:0] opResetContext = 4'd13;
    localparam logic [3:0] opNop = 4'd15;

    localparam logic [2:0] aluAdd = 3'd0;
    localparam logic [2:0] aluSub = 3'd1;
    localparam logic [2:0] aluAnd = 3'd2;
    localparam logic [2:0] aluOr = 3'd3;
    localparam logic [2:0] aluXor = 3'd4;
    localparam logic [2:0] aluPassB = 3'd5;

    localparam logic [2:0] actionNone = 3'd0;
    localparam logic [2:0] actionWriteAlu = 3'd1;
    localparam logic [2:0] actionResetContext = 3'd2;
    localparam logic [2:0] actionWriteMemory = 3'd3;
    localparam logic [2:0] actionEnterPrivileged = 3'd4;

    // **************************************************
    // instruction formats
    // **************************************************

    typedef struct packed {
        logic [3:0] opcode;
        logic [3:0] dest;
        logic [3:0] sourceA;
        logic [3:0] sourceB;
        logic [15:0] spare;
    } registerFormat;

    typedef struct packed {
        logic [3:0] opcode;
        logic [3:0] dest;
        logic [3:0] sourceA;
        logic [19:0] immediate;
    } immediateFormat;

    // both views share the opcode, dest and source A positions.
    typedef union packed {
        registerFormat registerView;
        immediateFormat immediateView;
    } instructionWord;

endpackage

`default_nettype wire
